// File: fbc_params.svh
`ifndef FBC_PARAMS_SVH
`define FBC_PARAMS_SVH

// ====================
// Serial timing
// ====================

// Clock cycles per bit for about 9600 baud from the 1 MHz board clock.
`define FBC_CLKS_PER_BIT 104

// Entries in each of the tx and rx queues.
`define FBC_FIFO_DEPTH 8

// ====================
// Endpoint numbers
// ====================

// Byte address on the host bus is the endpoint number times four.
`define FBC_EP_CTRL    6'h01
`define FBC_EP_TXDATA  6'h02
`define FBC_EP_STATUS  6'h20
`define FBC_EP_LED     6'h21
`define FBC_EP_RXPOP   6'h22
`define FBC_EP_TXCNT   6'h23
`define FBC_EP_RXCNT   6'h24
`define FBC_EP_ERRCNT  6'h25

`endif

// File: fbcPkg.sv
`default_nettype none

package fbcPkg;

	// Host control word at endpoint 0x01.
	typedef struct packed {
		logic [13:0] reserved;
		logic        clearStats;
		logic        linkEnable;
	} ctrlT;

	// One received byte and its framing result.
	typedef struct packed {
		logic       frameErr;
		logic [7:0] data;
	} rxEntryT;

	// Status word at endpoint 0x20.
	// Bit 0 is the synchronized STATE pin.
	typedef struct packed {
		logic [4:0] reserved;
		logic [3:0] rxLevel;
		logic [3:0] txLevel;
		logic       rxOverflow;
		logic       txOverflow;
		logic       btState;
	} statusT;

	// AXI response codes used by the slave.
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axiRespT;

endpackage

`default_nettype wire

// File: hostEpIf.sv
`timescale 1ns/100ps
`default_nettype none

interface hostEpIf;
	import fbcPkg::*;

	// Host to link on the wire-in side.
	ctrlT        ctrl;
	logic [7:0]  txData;
	logic        txPush;
	logic        rxPop;

	// Link to host on the wire-out side.
	rxEntryT     rxHead;
	logic        rxHeadValid;
	statusT      status;
	logic [7:0]  lastRx;
	logic [15:0] txCount;
	logic [15:0] rxCount;
	logic [15:0] errCount;

	modport host (
		output ctrl, txData, txPush, rxPop,
		input  rxHead, rxHeadValid, status, lastRx, txCount, rxCount, errCount
	);

	modport link (
		input  ctrl, txData, txPush, rxPop,
		output rxHead, rxHeadValid, status, lastRx, txCount, rxCount, errCount
	);

endinterface

`default_nettype wire

// File: msgFifo.sv
`timescale 1ns/100ps
`default_nettype none
`include "fbc_params.svh"

module msgFifo #(
	parameter int DEPTH = `FBC_FIFO_DEPTH,
	parameter type itemT = logic [7:0]
) (
	input  logic                         clock,
	input  logic                         arstN,
	input  logic                         push,
	input  itemT                         pushItem,
	input  logic                         pop,
	output itemT                         popItem,
	output logic                         full,
	output logic                         empty,
	output logic [$clog2(DEPTH + 1)-1:0] level
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int LW = $clog2(DEPTH + 1);

	itemT          mem [DEPTH];
	logic [AW-1:0] wrPtr;
	logic [AW-1:0] rdPtr;
	logic [LW-1:0] count;
	logic          doPush;
	logic          doPop;

	function automatic logic [AW-1:0] nextPtr(input logic [AW-1:0] ptr);
		nextPtr = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// Refuse a push when full and a pop when empty.
	assign doPush = push && !full;
	assign doPop  = pop && !empty;

	assign full    = (count == LW'(DEPTH));
	assign empty   = (count == '0);
	assign level   = count;
	assign popItem = mem[rdPtr];

	always_ff @(posedge clock) begin
		if (doPush)
			mem[wrPtr] <= pushItem;
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: uartTx.sv
`timescale 1ns/100ps
`default_nettype none
`include "fbc_params.svh"

module uartTx #(
	parameter int CLKS_PER_BIT = `FBC_CLKS_PER_BIT
) (
	input  logic       clock,
	input  logic       arstN,
	input  logic       start,
	input  logic [7:0] data,
	output logic       busy,
	output logic       txd
);

	localparam int CW = $clog2(CLKS_PER_BIT);

	logic [CW-1:0] clkCnt;
	logic [3:0]    bitCnt;
	logic [8:0]    shiftReg;
	logic          bitDone;

	assign bitDone = (clkCnt == CW'(CLKS_PER_BIT - 1));

	// Bit 0 is the start bit, 1 to 8 data, 9 the stop bit.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			busy   <= 1'b0;
			txd    <= 1'b1;
			clkCnt <= '0;
			bitCnt <= '0;
		end else if (!busy) begin
			if (start) begin
				busy   <= 1'b1;
				txd    <= 1'b0;
				clkCnt <= '0;
				bitCnt <= '0;
			end
		end else if (bitDone) begin
			clkCnt <= '0;
			if (bitCnt == 4'd9) begin
				busy <= 1'b0;
			end else begin
				txd    <= shiftReg[0];
				bitCnt <= bitCnt + 1'b1;
			end
		end else begin
			clkCnt <= clkCnt + 1'b1;
		end
	end

	// Stop bit rides at the top and falls out last.
	always_ff @(posedge clock) begin
		if (!busy && start)
			shiftReg <= {1'b1, data};
		else if (busy && bitDone)
			shiftReg <= {1'b1, shiftReg[8:1]};
	end

endmodule

`default_nettype wire

// File: uartRx.sv
`timescale 1ns/100ps
`default_nettype none
`include "fbc_params.svh"

module uartRx #(
	parameter int CLKS_PER_BIT = `FBC_CLKS_PER_BIT
) (
	input  logic            clock,
	input  logic            arstN,
	input  logic            enable,
	input  logic            rxd,
	output logic            valid,
	output fbcPkg::rxEntryT entry
);

	localparam int CW = $clog2(CLKS_PER_BIT);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rxStateT;

	rxStateT       state;
	logic [1:0]    rxSync;
	logic          rxPrev;
	logic          rxBit;
	logic [CW-1:0] clkCnt;
	logic [2:0]    bitCnt;
	logic [7:0]    shiftReg;
	logic          halfDone;
	logic          bitDone;

	assign rxBit    = rxSync[1];
	assign halfDone = (clkCnt == CW'(CLKS_PER_BIT / 2 - 1));
	assign bitDone  = (clkCnt == CW'(CLKS_PER_BIT - 1));

	// Line idles high.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			rxSync <= 2'b11;
			rxPrev <= 1'b1;
		end else begin
			rxSync <= {rxSync[0], rxd};
			rxPrev <= rxBit;
		end
	end

	// ====================
	// Frame FSM
	// ====================
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state  <= RX_IDLE;
			clkCnt <= '0;
			bitCnt <= '0;
			valid  <= 1'b0;
		end else begin
			valid  <= 1'b0;
			clkCnt <= clkCnt + 1'b1;
			if (!enable) begin
				state <= RX_IDLE;
			end else begin
				case (state)
					RX_IDLE: if (rxPrev && !rxBit) begin
						state  <= RX_START;
						clkCnt <= '0;
					end
					// Glitch shorter than half a bit is dropped.
					RX_START: if (halfDone) begin
						clkCnt <= '0;
						bitCnt <= '0;
						state  <= rxBit ? RX_IDLE : RX_DATA;
					end
					RX_DATA: if (bitDone) begin
						clkCnt <= '0;
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == 3'd7)
							state <= RX_STOP;
					end
					RX_STOP: if (bitDone) begin
						valid <= 1'b1;
						state <= RX_IDLE;
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// LSB first, so shift in from the top.
	always_ff @(posedge clock) begin
		if (state == RX_DATA && bitDone)
			shiftReg <= {rxBit, shiftReg[7:1]};
		if (state == RX_STOP && bitDone) begin
			entry.data     <= shiftReg;
			entry.frameErr <= !rxBit;
		end
	end

endmodule

`default_nettype wire

// File: btLinkCtrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "fbc_params.svh"

module btLinkCtrl (
	input  logic         clock,
	input  logic         arstN,
	hostEpIf.link        ep,
	input  logic         btState,
	input  logic         rxd,
	output logic         btEnable,
	output logic         txd,
	output logic [7:0]   led
);
	import fbcPkg::*;

	localparam int LW = $clog2(`FBC_FIFO_DEPTH + 1);

	logic          linkEnable;
	logic          clearStats;
	logic [7:0]    txByte;
	logic          txFull;
	logic          txEmpty;
	logic [LW-1:0] txLevel;
	logic          txBusy;
	logic          txStart;
	logic          rxValid;
	rxEntryT       rxEntry;
	logic          rxFull;
	logic          rxEmpty;
	logic [LW-1:0] rxLevel;
	logic [1:0]    stateSync;
	logic          txOverflow;
	logic          rxOverflow;
	logic [15:0]   txCount;
	logic [15:0]   rxCount;
	logic [15:0]   errCount;
	logic [7:0]    lastRx;
	statusT        status;

	assign linkEnable = ep.ctrl.linkEnable;
	assign clearStats = ep.ctrl.clearStats;
	assign btEnable   = linkEnable;

	// ====================
	// Transmit path
	// ====================
	assign txStart = linkEnable && !txEmpty && !txBusy;

	msgFifo #(.DEPTH(`FBC_FIFO_DEPTH), .itemT(logic [7:0])) txFifo (
		.clock    (clock),
		.arstN    (arstN),
		.push     (ep.txPush),
		.pushItem (ep.txData),
		.pop      (txStart),
		.popItem  (txByte),
		.full     (txFull),
		.empty    (txEmpty),
		.level    (txLevel)
	);

	uartTx txUart (
		.clock (clock),
		.arstN (arstN),
		.start (txStart),
		.data  (txByte),
		.busy  (txBusy),
		.txd   (txd)
	);

	// ====================
	// Receive path
	// ====================
	uartRx rxUart (
		.clock  (clock),
		.arstN  (arstN),
		.enable (linkEnable),
		.rxd    (rxd),
		.valid  (rxValid),
		.entry  (rxEntry)
	);

	msgFifo #(.DEPTH(`FBC_FIFO_DEPTH), .itemT(rxEntryT)) rxFifo (
		.clock    (clock),
		.arstN    (arstN),
		.push     (rxValid),
		.pushItem (rxEntry),
		.pop      (ep.rxPop),
		.popItem  (ep.rxHead),
		.full     (rxFull),
		.empty    (rxEmpty),
		.level    (rxLevel)
	);

	assign ep.rxHeadValid = !rxEmpty;

	// Counters and sticky flags are held at zero by clearStats.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			txCount    <= '0;
			rxCount    <= '0;
			errCount   <= '0;
			txOverflow <= 1'b0;
			rxOverflow <= 1'b0;
		end else if (clearStats) begin
			txCount    <= '0;
			rxCount    <= '0;
			errCount   <= '0;
			txOverflow <= 1'b0;
			rxOverflow <= 1'b0;
		end else begin
			if (txStart)
				txCount <= txCount + 1'b1;
			if (rxValid)
				rxCount <= rxCount + 1'b1;
			if (rxValid && rxEntry.frameErr)
				errCount <= errCount + 1'b1;
			if (ep.txPush && txFull)
				txOverflow <= 1'b1;
			if (rxValid && rxFull)
				rxOverflow <= 1'b1;
		end
	end

	// STATE pin is asynchronous to the board clock.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			stateSync <= 2'b00;
			lastRx    <= 8'h00;
		end else begin
			stateSync <= {stateSync[0], btState};
			if (rxValid)
				lastRx <= rxEntry.data;
		end
	end

	// LEDs are active low.
	assign led = ~lastRx;

	always_comb begin
		status            = '0;
		status.btState    = stateSync[1];
		status.txOverflow = txOverflow;
		status.rxOverflow = rxOverflow;
		status.txLevel    = 4'(txLevel);
		status.rxLevel    = 4'(rxLevel);
	end

	assign ep.status   = status;
	assign ep.lastRx   = lastRx;
	assign ep.txCount  = txCount;
	assign ep.rxCount  = rxCount;
	assign ep.errCount = errCount;

endmodule

`default_nettype wire

// File: hostRegs.sv
`timescale 1ns/100ps
`default_nettype none
`include "fbc_params.svh"

module hostRegs (
	input  logic            clock,
	input  logic            arstN,
	input  logic [7:0]      awaddr,
	input  logic            awvalid,
	output logic            awready,
	input  logic [31:0]     wdata,
	input  logic [3:0]      wstrb,
	input  logic            wvalid,
	output logic            wready,
	output fbcPkg::axiRespT bresp,
	output logic            bvalid,
	input  logic            bready,
	input  logic [7:0]      araddr,
	input  logic            arvalid,
	output logic            arready,
	output logic [31:0]     rdata,
	output fbcPkg::axiRespT rresp,
	output logic            rvalid,
	input  logic            rready,
	hostEpIf.host           ep
);
	import fbcPkg::*;

	ctrlT       ctrlReg;
	logic [7:0] txDataReg;
	logic       txPushReg;
	logic       rxPopReg;
	logic       wrAccept;
	logic       rdAccept;
	logic       wrIsCtrl;
	logic       wrIsTx;
	logic [31:0] rdNext;
	axiRespT    rdResp;
	logic       rdIsPop;

	// ====================
	// Write channel
	// ====================
	assign wrAccept = awvalid && wvalid && !bvalid;
	assign awready  = wrAccept;
	assign wready   = wrAccept;
	assign wrIsCtrl = (awaddr == {`FBC_EP_CTRL, 2'b00});
	assign wrIsTx   = (awaddr == {`FBC_EP_TXDATA, 2'b00});

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			bvalid    <= 1'b0;
			ctrlReg   <= '0;
			txDataReg <= 8'h00;
			txPushReg <= 1'b0;
		end else begin
			txPushReg <= 1'b0;
			if (wrAccept) begin
				bvalid <= 1'b1;
				if (wrIsCtrl) begin
					if (wstrb[0])
						ctrlReg[7:0] <= wdata[7:0];
					if (wstrb[1])
						ctrlReg[15:8] <= wdata[15:8];
				end
				if (wrIsTx && wstrb[0]) begin
					txDataReg <= wdata[7:0];
					txPushReg <= 1'b1;
				end
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (wrAccept)
			bresp <= (wrIsCtrl || wrIsTx) ? OKAY : SLVERR;
	end

	// ====================
	// Read channel
	// ====================
	assign arready  = !rvalid;
	assign rdAccept = arvalid && arready;
	assign rdIsPop  = (araddr == {`FBC_EP_RXPOP, 2'b00});

	always_comb begin
		rdNext = '0;
		rdResp = OKAY;
		case (araddr)
			{`FBC_EP_CTRL, 2'b00}:   rdNext = {16'h0000, ctrlReg};
			{`FBC_EP_TXDATA, 2'b00}: rdNext = {24'h000000, txDataReg};
			{`FBC_EP_STATUS, 2'b00}: rdNext = {16'h0000, ep.status};
			{`FBC_EP_LED, 2'b00}:    rdNext = {24'h000000, ep.lastRx};
			{`FBC_EP_RXPOP, 2'b00}: begin
				// Empty queue reads as zero.
				if (ep.rxHeadValid)
					rdNext = {22'h000000, 1'b1, ep.rxHead};
			end
			{`FBC_EP_TXCNT, 2'b00}:  rdNext = {16'h0000, ep.txCount};
			{`FBC_EP_RXCNT, 2'b00}:  rdNext = {16'h0000, ep.rxCount};
			{`FBC_EP_ERRCNT, 2'b00}: rdNext = {16'h0000, ep.errCount};
			default:                 rdResp = SLVERR;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			rvalid   <= 1'b0;
			rxPopReg <= 1'b0;
		end else begin
			rxPopReg <= rdAccept && rdIsPop && ep.rxHeadValid;
			if (rdAccept)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (rdAccept) begin
			rdata <= rdNext;
			rresp <= rdResp;
		end
	end

	assign ep.ctrl   = ctrlReg;
	assign ep.txData = txDataReg;
	assign ep.txPush = txPushReg;
	assign ep.rxPop  = rxPopReg;

endmodule

`default_nettype wire

// File: fbcTop.sv
`timescale 1ns/100ps
`default_nettype none

module fbcTop (
	input  logic        clock,
	input  logic        arstN,
	// AXI4-Lite slave.
	input  logic [7:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [7:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	// HC-05 pins, named from the module side.
	input  logic        hc05State,
	input  logic        hc05Txd,
	output logic        hc05Enable,
	output logic        hc05Rxd,
	output logic [7:0]  led
);

	hostEpIf epIf ();

	hostRegs hostRegs (
		.clock   (clock),
		.arstN   (arstN),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.ep      (epIf.host)
	);

	// Module TXD feeds our receiver, our transmitter drives module RXD.
	btLinkCtrl btLinkCtrl (
		.clock    (clock),
		.arstN    (arstN),
		.ep       (epIf.link),
		.btState  (hc05State),
		.rxd      (hc05Txd),
		.btEnable (hc05Enable),
		.txd      (hc05Rxd),
		.led      (led)
	);

endmodule

`default_nettype wire

// File: tbFbcTop.sv
`timescale 1ns/100ps
`default_nettype none
`include "fbc_params.svh"

module tbFbcTop;
	import fbcPkg::*;

	localparam int CPB   = `FBC_CLKS_PER_BIT;
	localparam int DEPTH = `FBC_FIFO_DEPTH;

	typedef enum logic [2:0] {
		OP_WRITE, OP_READ, OP_SEND, OP_WAIT, OP_QUIET, OP_STATE, OP_PINS
	} opKindT;

	// arg is an address, a byte or a bit count. value is write data or the expected value.
	typedef struct packed {
		opKindT      kind;
		logic [31:0] arg;
		logic [31:0] value;
		logic [1:0]  resp;
	} opT;

	logic        clock;
	logic        arstN;
	logic [7:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [7:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic        hc05State;
	logic        hc05Txd;
	logic        hc05Enable;
	logic        hc05Rxd;
	logic [7:0]  led;

	opT          opTable[$];
	logic [8:0]  lineFrames[$];
	integer      seed;
	int          cycleCount;
	int          cycleLimit;
	int          valueErrors;
	int          respErrors;

	fbcTop i_dut (
		.clock      (clock),
		.arstN      (arstN),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.hc05State  (hc05State),
		.hc05Txd    (hc05Txd),
		.hc05Enable (hc05Enable),
		.hc05Rxd    (hc05Rxd),
		.led        (led)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycleCount = cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles, a handshake or frame never arrived", cycleCount);
			$display("Some tests failed");
			$finish;
		end
	end

	// ====================
	// Serial model
	// ====================

	// Decodes one frame on hc05Rxd, sampling mid-bit.
	task automatic captureFrame();
		logic [7:0] data;
		int k;
		@(negedge hc05Rxd);
		repeat (CPB / 2) @(posedge clock);
		if (hc05Rxd === 1'b0) begin
			for (k = 0; k < 8; k++) begin
				repeat (CPB) @(posedge clock);
				data[k] = hc05Rxd;
			end
			repeat (CPB) @(posedge clock);
			lineFrames.push_back({hc05Rxd, data});
		end
	endtask

	initial begin : lineMonitor
		forever
			captureFrame();
	end

	task automatic holdLine(input logic level);
		hc05Txd = level;
		repeat (CPB) @(posedge clock);
		#1;
	endtask

	// Start, eight data bits LSB first, stop, then one idle bit.
	task automatic sendFrame(input logic [7:0] data, input logic stopBit);
		int k;
		holdLine(1'b0);
		for (k = 0; k < 8; k++)
			holdLine(data[k]);
		holdLine(stopBit);
		holdLine(1'b1);
	endtask

	// ====================
	// AXI4-Lite master
	// ====================
	task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hf;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(negedge clock);
		while (!(awready && wready))
			@(negedge clock);
		@(posedge clock);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		bready  = 1'b1;
		@(negedge clock);
		while (!bvalid)
			@(negedge clock);
		resp = bresp;
		@(posedge clock);
		#1;
		bready = 1'b0;
	endtask

	task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		araddr  = addr;
		arvalid = 1'b1;
		@(negedge clock);
		while (!arready)
			@(negedge clock);
		@(posedge clock);
		#1;
		arvalid = 1'b0;
		rready  = 1'b1;
		@(negedge clock);
		while (!rvalid)
			@(negedge clock);
		data = rdata;
		resp = rresp;
		@(posedge clock);
		#1;
		rready = 1'b0;
	endtask

	// ====================
	// Stimulus table
	// ====================
	function automatic logic [7:0] randomByte();
		integer r;
		r = $random(seed);
		randomByte = r[7:0];
	endfunction

	function automatic logic [31:0] epAddr(input logic [5:0] ep);
		epAddr = {24'h000000, ep, 2'b00};
	endfunction

	// Status fields from bit 0 up.
	function automatic logic [31:0] statusWord(input logic bt, input logic txOv,
			input logic rxOv, input logic [3:0] txLvl, input logic [3:0] rxLvl);
		statusWord = {21'h0, rxLvl, txLvl, rxOv, txOv, bt};
	endfunction

	// Popped entry has valid in bit 9 and frameErr in bit 8.
	function automatic logic [31:0] rxWord(input logic frameErr, input logic [7:0] data);
		rxWord = {22'h0, 1'b1, frameErr, data};
	endfunction

	task automatic addOp(input opKindT kind, input logic [31:0] arg,
			input logic [31:0] value, input logic [1:0] resp);
		opT op;
		op.kind  = kind;
		op.arg   = arg;
		op.value = value;
		op.resp  = resp;
		opTable.push_back(op);
	endtask

	task automatic buildTable();
		logic [7:0] txBytes[$];
		logic [7:0] rxBytes[$];
		logic [7:0] b;
		int k;
		// Reset values, readback and response codes.
		addOp(OP_READ, epAddr(`FBC_EP_CTRL), 32'h0, OKAY);
		addOp(OP_PINS, 32'h0, 32'h0ff, OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_TXCNT), 32'h0, OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_STATUS), 32'h0, OKAY);
		addOp(OP_WRITE, epAddr(`FBC_EP_CTRL), 32'ha5a5_5601, OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_CTRL), 32'h0000_5601, OKAY);
		addOp(OP_PINS, 32'h0, 32'h1ff, OKAY);
		addOp(OP_WRITE, epAddr(`FBC_EP_CTRL), 32'h0, OKAY);
		addOp(OP_PINS, 32'h0, 32'h0ff, OKAY);
		addOp(OP_WRITE, 32'h40, 32'h1, SLVERR);
		addOp(OP_READ, epAddr(`FBC_EP_CTRL), 32'h0, OKAY);
		addOp(OP_READ, 32'h40, 32'h0, SLVERR);
		// Transmit path.
		addOp(OP_WRITE, epAddr(`FBC_EP_CTRL), 32'h1, OKAY);
		for (k = 0; k < 4; k++) begin
			b = randomByte();
			txBytes.push_back(b);
			addOp(OP_WRITE, epAddr(`FBC_EP_TXDATA), {24'h0, b}, OKAY);
		end
		for (k = 0; k < 4; k++)
			addOp(OP_WAIT, 32'h0, {24'h0, txBytes[k]}, OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_TXCNT), 32'd4, OKAY);
		// Receive path.
		for (k = 0; k < 3; k++) begin
			b = randomByte();
			rxBytes.push_back(b);
			addOp(OP_SEND, {24'h0, b}, 32'h1, OKAY);
		end
		addOp(OP_READ, epAddr(`FBC_EP_RXCNT), 32'd3, OKAY);
		addOp(OP_PINS, 32'h0, {23'h0, 1'b1, ~b}, OKAY);
		for (k = 0; k < 3; k++)
			addOp(OP_READ, epAddr(`FBC_EP_RXPOP), rxWord(1'b0, rxBytes[k]), OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_RXPOP), 32'h0, OKAY);
		// Low stop bit.
		b = randomByte();
		addOp(OP_SEND, {24'h0, b}, 32'h0, OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_RXPOP), rxWord(1'b1, b), OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_ERRCNT), 32'd1, OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_RXCNT), 32'd4, OKAY);
		// Disabled link fills the tx queue and overflows it.
		addOp(OP_WRITE, epAddr(`FBC_EP_CTRL), 32'h0, OKAY);
		txBytes.delete();
		for (k = 0; k < DEPTH + 2; k++) begin
			b = randomByte();
			txBytes.push_back(b);
			addOp(OP_WRITE, epAddr(`FBC_EP_TXDATA), {24'h0, b}, OKAY);
		end
		addOp(OP_QUIET, 32'd11, 32'h0, OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_STATUS),
			statusWord(1'b0, 1'b1, 1'b0, 4'(DEPTH), 4'h0), OKAY);
		addOp(OP_WRITE, epAddr(`FBC_EP_CTRL), 32'h1, OKAY);
		for (k = 0; k < DEPTH; k++)
			addOp(OP_WAIT, 32'h0, {24'h0, txBytes[k]}, OKAY);
		addOp(OP_QUIET, 32'd11, 32'h0, OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_TXCNT), 32'(4 + DEPTH), OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_STATUS),
			statusWord(1'b0, 1'b1, 1'b0, 4'h0, 4'h0), OKAY);
		addOp(OP_WRITE, epAddr(`FBC_EP_CTRL), 32'h3, OKAY);
		addOp(OP_WRITE, epAddr(`FBC_EP_CTRL), 32'h1, OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_TXCNT), 32'h0, OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_RXCNT), 32'h0, OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_ERRCNT), 32'h0, OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_STATUS), 32'h0, OKAY);
		// STATE pin.
		addOp(OP_STATE, 32'h1, 32'h0, OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_STATUS),
			statusWord(1'b1, 1'b0, 1'b0, 4'h0, 4'h0), OKAY);
		addOp(OP_STATE, 32'h0, 32'h0, OKAY);
		addOp(OP_READ, epAddr(`FBC_EP_STATUS), 32'h0, OKAY);
	endtask

	task automatic runOp(input opT op);
		logic [31:0] got;
		logic [1:0]  resp;
		logic [8:0]  frame;
		case (op.kind)
			OP_WRITE: begin
				axiWrite(op.arg[7:0], op.value, resp);
				if (resp !== op.resp) begin
					respErrors++;
					$display("error %0t: write to 0x%02h gave bresp %0d, expected %0d",
						$time, op.arg[7:0], resp, op.resp);
				end
			end
			OP_READ: begin
				axiRead(op.arg[7:0], got, resp);
				if (got !== op.value) begin
					valueErrors++;
					$display("error %0t: read of 0x%02h returned 0x%08h, expected 0x%08h",
						$time, op.arg[7:0], got, op.value);
				end
				if (resp !== op.resp) begin
					respErrors++;
					$display("error %0t: read of 0x%02h gave rresp %0d, expected %0d",
						$time, op.arg[7:0], resp, op.resp);
				end
			end
			OP_SEND: sendFrame(op.arg[7:0], op.value[0]);
			OP_WAIT: begin
				while (lineFrames.size() == 0)
					@(posedge clock);
				@(posedge clock);
				#1;
				frame = lineFrames.pop_front();
				if (frame !== {1'b1, op.value[7:0]}) begin
					valueErrors++;
					$display("error %0t: hc05Rxd frame 0x%03h, expected stop and 0x%02h",
						$time, frame, op.value[7:0]);
				end
			end
			OP_QUIET: begin
				repeat (op.arg * CPB) @(posedge clock);
				#1;
				if (lineFrames.size() != 0 || hc05Rxd !== 1'b1) begin
					valueErrors++;
					$display("error %0t: hc05Rxd is %b with %0d unexpected frames",
						$time, hc05Rxd, lineFrames.size());
				end
			end
			OP_STATE: begin
				hc05State = op.arg[0];
				repeat (4) @(posedge clock);
				#1;
			end
			OP_PINS: begin
				if ({hc05Enable, led} !== op.value[8:0]) begin
					valueErrors++;
					$display("error %0t: hc05Enable and led are 0x%03h, expected 0x%03h",
						$time, {hc05Enable, led}, op.value[8:0]);
				end
			end
			default: ;
		endcase
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin : mainSeq
		int frames;
		awaddr      = 8'h00;
		awvalid     = 1'b0;
		wdata       = 32'h0;
		wstrb       = 4'h0;
		wvalid      = 1'b0;
		bready      = 1'b0;
		araddr      = 8'h00;
		arvalid     = 1'b0;
		rready      = 1'b0;
		hc05State   = 1'b0;
		hc05Txd     = 1'b1;
		arstN       = 1'b0;
		seed        = 32'h35cd_b0f4;
		cycleCount  = 0;
		valueErrors = 0;
		respErrors  = 0;
		buildTable();
		// Each serial op lasts about eleven bit periods.
		frames = 0;
		foreach (opTable[i])
			if (opTable[i].kind inside {OP_SEND, OP_WAIT, OP_QUIET})
				frames++;
		cycleLimit = frames * 11 * CPB + 2000;
		repeat (8) @(posedge clock);
		#1;
		arstN = 1'b1;
		if (bvalid !== 1'b0 || rvalid !== 1'b0 || awready !== 1'b0 || wready !== 1'b0 ||
				hc05Enable !== 1'b0 || hc05Rxd !== 1'b1) begin
			valueErrors++;
			$display("error %0t: outputs are not at their reset values", $time);
		end
		foreach (opTable[i])
			runOp(opTable[i]);
		$display("Errors: %0d value, %0d response", valueErrors, respErrors);
		if (valueErrors == 0 && respErrors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
fbcPkg.sv
hostEpIf.sv
msgFifo.sv
uartTx.sv
uartRx.sv
btLinkCtrl.sv
hostRegs.sv
fbcTop.sv
tbFbcTop.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbFbcTop
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= Some tests failed

SOURCES := $(shell grep -v '^+' $(FILELIST)) fbc_params.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$rc

clean:
	rm -rf $(OBJ_DIR) $(LOG)
